// ==== hdl/fetch_pkg.sv ====
package fetch_pkg;

    // datapath and address width
    localparam int xlen = 32;

    // cache geometry with one word per line
    localparam int icache_index_w = 4;
    localparam int icache_lines = 1 << icache_index_w;
    localparam int icache_tag_w = xlen - icache_index_w - 2;

    localparam logic [xlen-1:0] reset_pc = '0;

    // icache controller states
    localparam logic [1:0] icache_idle = 2'd0;
    localparam logic [1:0] icache_lookup = 2'd1;
    localparam logic [1:0] icache_refill = 2'd2;

    // one fetch address seen flat or split into cache fields
    typedef union packed {
        logic [xlen-1:0] raw;
        struct packed {
            logic [icache_tag_w-1:0] tag;
            logic [icache_index_w-1:0] index;
            logic [1:0] offset;
        } f;
    } fetch_addr_u;

endpackage

// ==== hdl/fetch_if.sv ====
`timescale 1ns/1ps

// fetch request from pc_gen to icache
interface cache_req_if;
    import fetch_pkg::*;

    logic valid;
    fetch_addr_u addr;
    logic ready;
    // only meaningful in the ready cycle
    logic [xlen-1:0] data;

    modport requester (
        output valid,
        output addr,
        input ready,
        input data
    );

    modport responder (
        input valid,
        input addr,
        output ready,
        output data
    );
endinterface

// refill port toward instruction memory
interface imem_if;
    import fetch_pkg::*;

    logic valid;
    logic [xlen-1:0] addr;
    logic ready;
    logic [xlen-1:0] rdata;

    modport requester (
        output valid,
        output addr,
        input ready,
        input rdata
    );
endinterface

// ==== hdl/pc_gen.sv ====
`timescale 1ns/1ps

module pc_gen (
    input logic clk,
    input logic rst,
    input logic redirect_valid,
    input logic [fetch_pkg::xlen-1:0] redirect_pc,
    input logic stall,
    cache_req_if.requester req,
    output logic instr_valid,
    output logic [fetch_pkg::xlen-1:0] instr,
    output logic [fetch_pkg::xlen-1:0] instr_pc
);
    import fetch_pkg::*;

    // next fetch address
    fetch_addr_u pc;
    // address of the request in flight
    fetch_addr_u req_addr;
    logic busy;
    logic stale;
    logic launch;
    logic take;

    // new request only when the output slot is free or drains now
    assign launch = !busy && !redirect_valid && (!instr_valid || !stall);

    // word is kept unless a redirect made it stale
    assign take = busy && req.ready && !stale && !redirect_valid;

    assign req.valid = busy || launch;
    assign req.addr = busy ? req_addr : pc;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            pc.raw <= reset_pc;
            busy <= 1'b0;
            stale <= 1'b0;
            instr_valid <= 1'b0;
        end
        else
        begin
            if (launch)
                busy <= 1'b1;
            else if (req.ready)
                busy <= 1'b0;

            // redirect with a request in flight
            if (busy && !req.ready && redirect_valid)
                stale <= 1'b1;
            else if (req.ready)
                stale <= 1'b0;

            if (redirect_valid)
                pc.raw <= redirect_pc;
            else if (take)
                pc.raw <= pc.raw + xlen'(4);

            if (redirect_valid)
                instr_valid <= 1'b0;
            else if (take)
                instr_valid <= 1'b1;
            else if (!stall)
                instr_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (launch)
            req_addr <= pc;
        if (take)
        begin
            instr <= req.data;
            instr_pc <= req_addr.raw;
        end
    end

    // held output survives until downstream takes it
    a_stall_hold: assert property (@(posedge clk) disable iff (rst)
        instr_valid && stall && !redirect_valid
        |=> instr_valid && $stable(instr) && $stable(instr_pc));

endmodule

// ==== hdl/icache.sv ====
`timescale 1ns/1ps

module icache (
    input logic clk,
    input logic rst,
    input logic flush,
    cache_req_if.responder cpu,
    imem_if.requester mem
);
    import fetch_pkg::*;

    logic [1:0] state;
    // captured request address
    fetch_addr_u addr_q;

    logic [xlen-1:0] data_mem [icache_lines];
    logic [icache_tag_w-1:0] tag_mem [icache_lines];
    logic [icache_lines-1:0] line_valid;

    // lookup right after a refill
    logic fill_done;
    logic flush_pend;
    logic mem_valid_q;

    logic tag_eq;
    logic hit;
    logic refill_wait;
    logic fill_write;
    logic flush_apply;

    assign tag_eq = tag_mem[addr_q.f.index] == addr_q.f.tag;

    // a freshly filled line answers even if a flush cleared its valid bit
    assign hit = (state == icache_lookup) && tag_eq
        && (line_valid[addr_q.f.index] || fill_done);

    assign cpu.ready = hit;
    assign cpu.data = data_mem[addr_q.f.index];

    // word aligned refill address
    assign mem.valid = mem_valid_q;
    assign mem.addr = {addr_q.raw[xlen-1:2], 2'b00};

    assign refill_wait = (state == icache_refill) && !mem.ready;
    assign fill_write = (state == icache_refill) && mem.ready;

    // flush waits for an open refill to land first
    assign flush_apply = (flush || flush_pend) && !refill_wait;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state <= icache_idle;
            mem_valid_q <= 1'b0;
            fill_done <= 1'b0;
        end
        else
        begin
            case (state)
                icache_idle:
                begin
                    if (cpu.valid)
                        state <= icache_lookup;
                end
                icache_lookup:
                begin
                    fill_done <= 1'b0;
                    if (hit)
                    begin
                        state <= icache_idle;
                    end
                    else
                    begin
                        state <= icache_refill;
                        mem_valid_q <= 1'b1;
                    end
                end
                icache_refill:
                begin
                    if (mem.ready)
                    begin
                        state <= icache_lookup;
                        mem_valid_q <= 1'b0;
                        fill_done <= 1'b1;
                    end
                end
                default:
                begin
                    state <= icache_idle;
                    mem_valid_q <= 1'b0;
                end
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            line_valid <= '0;
            flush_pend <= 1'b0;
        end
        else
        begin
            flush_pend <= refill_wait && (flush || flush_pend);
            if (fill_write)
                line_valid[addr_q.f.index] <= 1'b1;
            // clear wins over the fill of the same edge
            if (flush_apply)
                line_valid <= '0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (state == icache_idle && cpu.valid)
            addr_q <= cpu.addr;
        if (fill_write)
        begin
            data_mem[addr_q.f.index] <= mem.rdata;
            tag_mem[addr_q.f.index] <= addr_q.f.tag;
        end
    end

    a_mem_in_refill: assert property (@(posedge clk) disable iff (rst)
        mem.valid |-> state == icache_refill);

    a_mem_addr_hold: assert property (@(posedge clk) disable iff (rst)
        mem.valid && !mem.ready |=> mem.valid && $stable(mem.addr));

    // answers only go to a live request
    a_ready_needs_valid: assert property (@(posedge clk) disable iff (rst)
        cpu.ready |-> cpu.valid && cpu.addr == addr_q);

endmodule

// ==== hdl/instr_stage.sv ====
`timescale 1ns/1ps

module instr_stage (
    input logic clk,
    input logic rst,
    input logic redirect_valid,
    input logic [fetch_pkg::xlen-1:0] redirect_pc,
    input logic flush,
    input logic stall,
    output logic instr_valid,
    output logic [fetch_pkg::xlen-1:0] instr,
    output logic [fetch_pkg::xlen-1:0] instr_pc,
    output logic imem_valid,
    output logic [fetch_pkg::xlen-1:0] imem_addr,
    input logic imem_ready,
    input logic [fetch_pkg::xlen-1:0] imem_rdata
);

    cache_req_if fetch_req ();
    imem_if imem_bus ();

    pc_gen u_pc_gen (
        .clk (clk),
        .rst (rst),
        .redirect_valid (redirect_valid),
        .redirect_pc (redirect_pc),
        .stall (stall),
        .req (fetch_req.requester),
        .instr_valid (instr_valid),
        .instr (instr),
        .instr_pc (instr_pc)
    );

    icache u_icache (
        .clk (clk),
        .rst (rst),
        .flush (flush),
        .cpu (fetch_req.responder),
        .mem (imem_bus.requester)
    );

    // memory side out to plain ports
    assign imem_valid = imem_bus.valid;
    assign imem_addr = imem_bus.addr;
    assign imem_bus.ready = imem_ready;
    assign imem_bus.rdata = imem_rdata;

endmodule

// ==== verif/imem_model.sv ====
`timescale 1ns/1ps

module imem_model (
    input logic clk,
    input logic rst,
    input logic valid,
    input logic [fetch_pkg::xlen-1:0] addr,
    output logic ready,
    output logic [fetch_pkg::xlen-1:0] rdata,
    output int req_count
);
    import fetch_pkg::*;

    integer seed = 70729;
    integer r;
    logic pending = 1'b0;
    logic [1:0] wait_cnt = 2'd0;
    logic ready_r = 1'b0;
    logic [xlen-1:0] rdata_r = '0;
    int count_r = 0;

    assign ready = ready_r;
    assign rdata = rdata_r;
    assign req_count = count_r;

    // fixed scramble of the word address
    function automatic logic [xlen-1:0] mem_word(input logic [xlen-1:0] a);
        return (a * 32'h9e37_79b1) ^ {a[15:0], a[31:16]} ^ 32'h5a5a_0f0f;
    endfunction

    // answers 1 to 4 cycles after the request shows up
    always @(posedge clk)
    begin
        #2;
        if (rst)
        begin
            ready_r = 1'b0;
            pending = 1'b0;
            count_r = 0;
        end
        else if (ready_r)
        begin
            ready_r = 1'b0;
        end
        else if (pending)
        begin
            if (wait_cnt == 2'd0)
            begin
                ready_r = 1'b1;
                rdata_r = mem_word(addr);
                count_r = count_r + 1;
                pending = 1'b0;
            end
            else
                wait_cnt = wait_cnt - 2'd1;
        end
        else if (valid)
        begin
            pending = 1'b1;
            r = $random(seed);
            wait_cnt = r[1:0];
        end
    end

endmodule

// ==== verif/tb_instr_stage.sv ====
`timescale 1ns/1ps

module tb_instr_stage;
    import fetch_pkg::*;

    localparam int clk_period = 40;
    localparam int n_trans = 3000;
    localparam int cycle_bound = 20;

    logic clk = 1'b0;
    logic rst;
    logic redirect_valid;
    logic [xlen-1:0] redirect_pc;
    logic flush;
    logic stall;
    logic instr_valid;
    logic [xlen-1:0] instr;
    logic [xlen-1:0] instr_pc;
    logic imem_valid;
    logic [xlen-1:0] imem_addr;
    logic imem_ready;
    logic [xlen-1:0] imem_rdata;
    int req_count;

    // cache side of the fetch request
    logic cache_valid;
    logic cache_ready;
    logic [xlen-1:0] cache_addr;

    integer seed = 70729;
    integer r;
    int delivered = 0;
    int exp_misses;
    logic [xlen-1:0] exp_pc;

    // mirror of valid bits and tags
    logic [icache_lines-1:0] mvalid;
    logic [icache_tag_w-1:0] mtag [icache_lines];
    logic flush_held;
    logic txn_open;
    logic lookup_due;
    logic [xlen-1:0] txn_addr;
    logic [icache_index_w-1:0] idx;
    logic miss;
    logic refill_wait;

    logic prev_valid;
    logic prev_stall;
    logic prev_redirect;
    logic [xlen-1:0] prev_instr;
    logic [xlen-1:0] prev_pc;

    always #(clk_period / 2) clk = ~clk;

    instr_stage u_instr_stage (
        .clk (clk),
        .rst (rst),
        .redirect_valid (redirect_valid),
        .redirect_pc (redirect_pc),
        .flush (flush),
        .stall (stall),
        .instr_valid (instr_valid),
        .instr (instr),
        .instr_pc (instr_pc),
        .imem_valid (imem_valid),
        .imem_addr (imem_addr),
        .imem_ready (imem_ready),
        .imem_rdata (imem_rdata)
    );

    imem_model u_imem (
        .clk (clk),
        .rst (rst),
        .valid (imem_valid),
        .addr (imem_addr),
        .ready (imem_ready),
        .rdata (imem_rdata),
        .req_count (req_count)
    );

    assign cache_valid = u_instr_stage.fetch_req.valid;
    assign cache_ready = u_instr_stage.fetch_req.ready;
    assign cache_addr = u_instr_stage.fetch_req.addr;

    function automatic logic [xlen-1:0] expected_word(input logic [xlen-1:0] a);
        return (a * 32'h9e37_79b1) ^ {a[15:0], a[31:16]} ^ 32'h5a5a_0f0f;
    endfunction

    task automatic check_eq(input string name, input logic [xlen-1:0] actual,
                            input logic [xlen-1:0] expected);
        if (actual !== expected)
        begin
            $display("** Error: %s is %h, expected %h at %0t", name, actual, expected, $time);
            $display("TEST FAIL");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    // targets in a 64 word window so lines get reused
    task automatic drive_random();
        r = $random(seed);
        redirect_valid = (r[4:0] == 5'd0);
        redirect_pc = {23'd0, 1'b1, r[10:5], 2'b00};
        stall = (r[12:11] == 2'd0);
        flush = (r[20:15] == 6'd0);
    endtask

    always @(negedge clk)
    begin
        if (rst)
        begin
            check_eq("instr_valid", xlen'(instr_valid), '0);
            check_eq("imem_valid", xlen'(imem_valid), '0);
            mvalid = '0;
            flush_held = 1'b0;
            txn_open = 1'b0;
            lookup_due = 1'b0;
            exp_misses = 0;
            exp_pc = reset_pc;
            prev_valid = 1'b0;
            prev_stall = 1'b0;
            prev_redirect = 1'b0;
        end
        else
        begin
            // held word must not move
            if (prev_valid && prev_stall && !prev_redirect)
            begin
                check_eq("instr_valid", xlen'(instr_valid), xlen'(1));
                check_eq("instr", instr, prev_instr);
                check_eq("instr_pc", instr_pc, prev_pc);
            end
            else if (instr_valid)
            begin
                check_eq("instr_pc", instr_pc, exp_pc);
                check_eq("instr", instr, expected_word(exp_pc));
                exp_pc = exp_pc + 32'd4;
                delivered = delivered + 1;
            end
            if (redirect_valid)
                exp_pc = redirect_pc;

            if (txn_open)
            begin
                if (lookup_due)
                begin
                    idx = txn_addr[icache_index_w+1:2];
                    miss = !(mvalid[idx] && mtag[idx] == txn_addr[xlen-1:icache_index_w+2]);
                    if (miss)
                        exp_misses = exp_misses + 1;
                    check_eq("cache_ready", xlen'(cache_ready), xlen'(!miss));
                    lookup_due = 1'b0;
                end
                if (imem_valid && imem_ready)
                    check_eq("imem_addr", imem_addr, {txn_addr[xlen-1:2], 2'b00});
                if (cache_ready)
                begin
                    check_eq("imem_req_count", req_count, exp_misses);
                    txn_open = 1'b0;
                end
            end
            else if (cache_valid)
            begin
                txn_open = 1'b1;
                lookup_due = 1'b1;
                txn_addr = cache_addr;
            end

            // mirror for the next cycle where a flush waits out an open refill
            refill_wait = imem_valid && !imem_ready;
            if (imem_valid && imem_ready)
            begin
                mvalid[imem_addr[icache_index_w+1:2]] = 1'b1;
                mtag[imem_addr[icache_index_w+1:2]] = imem_addr[xlen-1:icache_index_w+2];
            end
            if ((flush || flush_held) && !refill_wait)
                mvalid = '0;
            flush_held = refill_wait && (flush || flush_held);

            prev_valid = instr_valid;
            prev_stall = stall;
            prev_redirect = redirect_valid;
            prev_instr = instr;
            prev_pc = instr_pc;
        end
    end

    initial
    begin
        rst = 1'b1;
        redirect_valid = 1'b0;
        redirect_pc = '0;
        flush = 1'b0;
        stall = 1'b0;
        repeat (10) @(posedge clk);
        #2;
        rst = 1'b0;
        while (delivered < n_trans)
        begin
            @(posedge clk);
            #2;
            drive_random();
        end
        $display("%0d words delivered, %0d refills", delivered, exp_misses);
        $display("TEST PASS");
        $finish;
    end

    initial
    begin
        #((n_trans * cycle_bound + 10) * clk_period);
        $display("watchdog expired with %0d of %0d words delivered", delivered, n_trans);
        $display("TEST FAIL");
        $fatal(1, "watchdog");
    end

endmodule

// ==== vlog.f ====
hdl/fetch_pkg.sv
hdl/fetch_if.sv
hdl/pc_gen.sv
hdl/icache.sv
hdl/instr_stage.sv
verif/imem_model.sv
verif/tb_instr_stage.sv

// ==== run.sh ====
#!/bin/sh
# build and run the instruction fetch testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_instr_stage -f vlog.f -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -qx "TEST PASS" sim.log
then
    echo "simulation passed"
else
    echo "simulation failed, see sim.log"
    exit 1
fi
